// File: build.f
soc_addr_pkg.sv
dcache_pkg.sv
dcache_ifs.sv
mem_ctrl.sv
dcache.sv
linefill_buf.sv
line_write_buf.sv
dmem_sys.sv
tb_mem_model.sv
tb_dmem_sys.sv

// File: run_sim.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_dmem_sys -f build.f -o sim_tb

# Simulation status is judged from the log
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
   exit 1
fi
exit 0

// File: tb_dmem_sys.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dmem_sys;
   import soc_addr_pkg::*;

   localparam region_t PERIPH  = 4'h4;
   localparam int      TIMEOUT = 300;

   logic  Clk, rst_i, req_i, req_we_i;
   addr_t req_addr_i;
   word_t req_wdata_i;
   logic  done_o, busy_o;
   word_t rdata_o;
   logic  per_rd_o, per_wr_o, per_done_i;
   addr_t per_addr_o;
   word_t per_wdata_o, per_rdata_i;
   logic  mem_ar_o, mem_rvalid_i, mem_aw_o, mem_wvalid_o, mem_wready_i;
   addr_t mem_araddr_o, mem_awaddr_o;
   word_t mem_rdata_i, mem_wdata_o;

   // Monitor state
   int    cyc, req_cyc, done_cyc, first_beat_cyc, rbeats;
   int    ar_count, aw_count, per_count;
   addr_t ar_addr, aw_addr, per_addr_seen;
   word_t per_wdata_seen, done_data;
   logic  per_we_seen, done_seen;
   word_t wq [$];

   // Reference model of memory and cache tags
   word_t       ref_mem [addr_t];
   logic [23:0] ref_tag [8];
   logic        ref_valid [8];
   logic        ref_dirty [8];
   logic [15:0] lfsr_q;

   dmem_sys #(.PERIPH_REGION(PERIPH)) i_dmem_sys (.*);

   tb_mem_model i_mem_model (
      .Clk, .rst_i,
      .mem_ar_i (mem_ar_o), .mem_araddr_i (mem_araddr_o),
      .mem_rvalid_o (mem_rvalid_i), .mem_rdata_o (mem_rdata_i),
      .mem_aw_i (mem_aw_o), .mem_awaddr_i (mem_awaddr_o),
      .mem_wvalid_i (mem_wvalid_o), .mem_wdata_i (mem_wdata_o),
      .mem_wready_o (mem_wready_i),
      .per_rd_i (per_rd_o), .per_wr_i (per_wr_o), .per_addr_i (per_addr_o),
      .per_wdata_i (per_wdata_o), .per_done_o (per_done_i), .per_rdata_o (per_rdata_i)
   );

   initial begin
      Clk = 1'b0;
      forever #50 Clk = ~Clk;
   end

   ////////////////////////////////////////
   // Failure reporting
   ////////////////////////////////////////

   task automatic stop_with_errors();
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped");
   endtask

   task automatic report_error(input string msg);
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      stop_with_errors();
   endtask

   task automatic timed_out(input string what);
      $display("Timeout while waiting for %s", what);
      stop_with_errors();
   endtask

   ////////////////////////////////////////
   // Reference helpers and LFSR
   ////////////////////////////////////////

   function automatic word_t ref_read(addr_t a);
      if (ref_mem.exists(a)) return ref_mem[a];
      return {2'b00, a[31:2]} ^ 32'hA5A5_0000;
   endfunction

   function automatic logic [15:0] lfsr_next(logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      repeat (n) begin
         lfsr_q = lfsr_next(lfsr_q);
         v = {v[30:0], lfsr_q[0]};
      end
   endtask

   ////////////////////////////////////////
   // Port monitor
   ////////////////////////////////////////

   always @(posedge Clk) begin
      cyc++;
      if (req_i) req_cyc = cyc;
      if (done_o) begin
         done_seen = 1'b1;
         done_cyc  = cyc;
         done_data = rdata_o;
      end
      if (mem_ar_o) begin
         ar_count++;
         ar_addr = mem_araddr_o;
      end
      if (mem_rvalid_i) begin
         rbeats++;
         if (rbeats == 1) first_beat_cyc = cyc;
         assert (busy_o) else report_error("busy_o low during a read beat");
      end
      if (mem_aw_o) begin
         aw_count++;
         aw_addr = mem_awaddr_o;
      end
      if (mem_wvalid_o && mem_wready_i) wq.push_back(mem_wdata_o);
      if (per_rd_o || per_wr_o) begin
         per_count++;
         per_addr_seen  = per_addr_o;
         per_wdata_seen = per_wdata_o;
         per_we_seen    = per_wr_o;
      end
   end

   ////////////////////////////////////////
   // Access tasks
   ////////////////////////////////////////

   task automatic wait_idle();
      for (int i = 0; i < TIMEOUT && busy_o; i++) begin
         @(posedge Clk);
         #10;
      end
      if (busy_o) timed_out("busy_o to fall");
   endtask

   task automatic access(input logic we, input addr_t addr, input word_t wdata);
      addr_view_u v;
      logic       periph, hit, evict;
      logic [2:0] idx;
      addr_t      victim;
      word_t      expected;
      int         ar0, aw0, per0;
      v        = addr;
      idx      = v.cache_view.index;
      periph   = (v.region_view.region == PERIPH);
      hit      = ref_valid[idx] && (ref_tag[idx] == v.cache_view.tag);
      evict    = !periph && !hit && ref_valid[idx] && ref_dirty[idx];
      victim   = {ref_tag[idx], idx, 5'b00000};
      expected = periph ? (addr ^ 32'h0F0F_0F0F) : ref_read(addr);
      wait_idle();
      ar0       = ar_count;
      aw0       = aw_count;
      per0      = per_count;
      rbeats    = 0;
      done_seen = 1'b0;
      wq.delete();
      req_i       = 1'b1;
      req_we_i    = we;
      req_addr_i  = addr;
      req_wdata_i = wdata;
      @(posedge Clk);
      #10;
      req_i    = 1'b0;
      req_we_i = 1'b0;
      for (int i = 0; i < TIMEOUT && !done_seen; i++) begin
         @(posedge Clk);
         #10;
      end
      if (!done_seen) timed_out("done_o");
      if (!we) assert (done_data == expected)
         else report_error($sformatf("read %h gave %h, expected %h", addr, done_data, expected));
      if (periph) begin
         assert (per_count == per0 + 1) else report_error("peripheral strobe count");
         assert (per_addr_seen == addr) else report_error("peripheral address");
         assert (per_we_seen == we) else report_error("peripheral direction");
         if (we) assert (per_wdata_seen == wdata) else report_error("peripheral write data");
      end else if (hit) begin
         assert (done_cyc == req_cyc + 1) else report_error("hit latency not 1 cycle");
      end else begin
         assert (ar_count == ar0 + 1 && ar_addr == addr) else report_error("read burst request");
         if (!we) assert (done_cyc == first_beat_cyc + 2)
            else report_error("miss done not 2 cycles after first beat");
      end
      wait_idle();
      if (!periph && !hit) assert (rbeats == 8) else report_error("busy_o fell before 8 beats");
      if (periph || hit) begin
         assert (ar_count == ar0) else report_error("unexpected mem_ar_o");
      end else begin
         assert (ar_count == ar0 + 1) else report_error("more than one mem_ar_o");
      end
      if (evict) begin
         assert (aw_count == aw0 + 1 && aw_addr == victim) else report_error("eviction address");
         assert (wq.size() == 8) else report_error("eviction beat count");
         for (int i = 0; i < 8; i++)
            assert (wq[i] == ref_read(victim + 32'(i * 4)))
               else report_error($sformatf("eviction beat %0d wrong", i));
      end else begin
         assert (aw_count == aw0) else report_error("unexpected mem_aw_o");
      end
      // Reference update
      if (!periph) begin
         if (we) ref_mem[addr] = wdata;
         if (!hit) begin
            ref_valid[idx] = 1'b1;
            ref_tag[idx]   = v.cache_view.tag;
            ref_dirty[idx] = we;
         end else if (we) begin
            ref_dirty[idx] = 1'b1;
         end
      end
   endtask

   function automatic addr_t cached_addr(logic [7:0] t, logic [2:0] idx, logic [2:0] w);
      return {4'h1, 12'h000, t, idx, w, 2'b00};
   endfunction

   task automatic check_quiet(input string when);
      assert (!busy_o && !done_o && !per_rd_o && !per_wr_o && !mem_ar_o && !mem_aw_o
              && !mem_wvalid_o) else report_error($sformatf("outputs not low %s", when));
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial begin : main
      logic [31:0] t, idx, w, d, r;
      lfsr_q      = 16'd61971;
      rst_i       = 1'b1;
      req_i       = 1'b0;
      req_we_i    = 1'b0;
      req_addr_i  = '0;
      req_wdata_i = '0;
      cyc         = 0;
      rbeats      = 0;
      ar_count    = 0;
      aw_count    = 0;
      per_count   = 0;
      for (int i = 0; i < 8; i++) begin
         ref_valid[i] = 1'b0;
         ref_dirty[i] = 1'b0;
         ref_tag[i]   = '0;
      end
      repeat (5) begin
         @(posedge Clk);
         #10 check_quiet("during reset");
      end
      rst_i = 1'b0;
      repeat (3) begin
         @(posedge Clk);
         #10 check_quiet("after reset");
      end

      // Read miss, then hits within the line
      rand_bits(8, t);
      rand_bits(3, idx);
      rand_bits(3, w);
      access(1'b0, cached_addr(t[7:0], idx[2:0], w[2:0]), '0);
      for (int k = 1; k < 4; k++)
         access(1'b0, cached_addr(t[7:0], idx[2:0], w[2:0] ^ 3'(k)), '0);

      // Write hit, readback, conflicting miss and old address reread
      rand_bits(32, d);
      access(1'b1, cached_addr(t[7:0], idx[2:0], w[2:0] ^ 3'd5), d);
      access(1'b0, cached_addr(t[7:0], idx[2:0], w[2:0] ^ 3'd5), '0);
      access(1'b0, cached_addr(t[7:0] ^ 8'h01, idx[2:0], w[2:0]), '0);
      access(1'b0, cached_addr(t[7:0], idx[2:0], w[2:0] ^ 3'd5), '0);

      // Peripheral accesses, reads and writes in turn
      for (int k = 0; k < 6; k++) begin
         rand_bits(26, r);
         rand_bits(32, d);
         access(k[0], {PERIPH, r[25:0], 2'b00}, d);
      end

      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_model (
   input  logic                Clk,
   input  logic                rst_i,
   // Memory read channel
   input  logic                mem_ar_i,
   input  soc_addr_pkg::addr_t mem_araddr_i,
   output logic                mem_rvalid_o,
   output soc_addr_pkg::word_t mem_rdata_o,
   // Memory write channel
   input  logic                mem_aw_i,
   input  soc_addr_pkg::addr_t mem_awaddr_i,
   input  logic                mem_wvalid_i,
   input  soc_addr_pkg::word_t mem_wdata_i,
   output logic                mem_wready_o,
   // Peripheral port
   input  logic                per_rd_i,
   input  logic                per_wr_i,
   input  soc_addr_pkg::addr_t per_addr_i,
   input  soc_addr_pkg::word_t per_wdata_i,
   output logic                per_done_o,
   output soc_addr_pkg::word_t per_rdata_o
);
   import soc_addr_pkg::*;

   word_t       shadow [addr_t];
   logic [15:0] lfsr_q;
   addr_t       wbase;
   int          wbeat;

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   function automatic word_t init_word(addr_t a);
      return {2'b00, a[31:2]} ^ 32'hA5A5_0000;
   endfunction

   function automatic word_t shadow_read(addr_t a);
      if (shadow.exists(a)) return shadow[a];
      return init_word(a);
   endfunction

   function automatic logic [15:0] lfsr_next(logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit taken
   task automatic rand_bits(input int n, output int v);
      v = 0;
      repeat (n) begin
         lfsr_q = lfsr_next(lfsr_q);
         v = (v << 1) | lfsr_q[0];
      end
   endtask

   initial begin
      lfsr_q       = 16'd61971;
      mem_rvalid_o = 1'b0;
      mem_rdata_o  = '0;
      mem_wready_o = 1'b0;
      per_done_o   = 1'b0;
      per_rdata_o  = '0;
   end

   ////////////////////////////////////////
   // Read channel, wrapping bursts
   ////////////////////////////////////////

   initial begin : read_channel
      addr_t base;
      addr_t a;
      int    gap;
      forever begin
         @(posedge Clk);
         if (mem_ar_i && !rst_i) begin
            base = mem_araddr_i;
            for (int b = 0; b < 8; b++) begin
               rand_bits(2, gap);
               repeat (gap) begin
                  #10 mem_rvalid_o = 1'b0;
                  @(posedge Clk);
               end
               a = {base[31:5], 3'(base[4:2] + b), 2'b00};
               #10;
               mem_rvalid_o = 1'b1;
               mem_rdata_o  = shadow_read(a);
               @(posedge Clk);
            end
            #10 mem_rvalid_o = 1'b0;
         end
      end
   end

   ////////////////////////////////////////
   // Write channel with random ready
   ////////////////////////////////////////

   initial begin : write_channel
      int r;
      forever begin
         @(posedge Clk);
         if (mem_aw_i) begin
            wbase = mem_awaddr_i;
            wbeat = 0;
         end
         if (mem_wvalid_i && mem_wready_o) begin
            shadow[wbase + 32'(wbeat * 4)] = mem_wdata_i;
            wbeat++;
         end
         rand_bits(1, r);
         #10 mem_wready_o = r[0];
      end
   end

   ////////////////////////////////////////
   // Peripheral responder
   ////////////////////////////////////////

   initial begin : periph_responder
      addr_t a;
      int    dly;
      forever begin
         @(posedge Clk);
         if (per_rd_i || per_wr_i) begin
            a = per_addr_i;
            if (per_wr_i) $display("Peripheral write %h <= %h", per_addr_i, per_wdata_i);
            rand_bits(2, dly);
            repeat (dly) @(posedge Clk);
            #10;
            per_done_o  = 1'b1;
            per_rdata_o = a ^ 32'h0F0F_0F0F;
            @(posedge Clk);
            #10 per_done_o = 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// File: dmem_sys.sv
`timescale 1ns/10ps
`default_nettype none

module dmem_sys #(
   parameter soc_addr_pkg::region_t PERIPH_REGION = 4'h4
) (
   input  logic                Clk,
   input  logic                rst_i,
   // Core side
   input  logic                req_i,
   input  logic                req_we_i,
   input  soc_addr_pkg::addr_t req_addr_i,
   input  soc_addr_pkg::word_t req_wdata_i,
   output logic                done_o,
   output logic                busy_o,
   output soc_addr_pkg::word_t rdata_o,
   // Peripheral word port
   output logic                per_rd_o,
   output logic                per_wr_o,
   output soc_addr_pkg::addr_t per_addr_o,
   output soc_addr_pkg::word_t per_wdata_o,
   input  logic                per_done_i,
   input  soc_addr_pkg::word_t per_rdata_i,
   // Memory read channel
   output logic                mem_ar_o,
   output soc_addr_pkg::addr_t mem_araddr_o,
   input  logic                mem_rvalid_i,
   input  soc_addr_pkg::word_t mem_rdata_i,
   // Memory write channel
   output logic                mem_aw_o,
   output logic                mem_wvalid_o,
   output soc_addr_pkg::addr_t mem_awaddr_o,
   output soc_addr_pkg::word_t mem_wdata_o,
   input  logic                mem_wready_i
);

   dreq_if  dreq ();
   fill_if  fill ();
   evict_if evict ();

   mem_ctrl #(.PERIPH_REGION(PERIPH_REGION)) i_mem_ctrl (
      .Clk, .rst_i,
      .req_i, .req_we_i, .req_addr_i, .req_wdata_i,
      .done_o, .busy_o, .rdata_o,
      .per_rd_o, .per_wr_o, .per_addr_o, .per_wdata_o, .per_done_i, .per_rdata_i,
      .dreq (dreq.master)
   );

   dcache i_dcache (
      .Clk, .rst_i,
      .dreq  (dreq.slave),
      .fill  (fill.master),
      .evict (evict.master)
   );

   linefill_buf i_linefill_buf (
      .Clk, .rst_i,
      .fill (fill.slave),
      .mem_ar_o, .mem_araddr_o, .mem_rvalid_i, .mem_rdata_i
   );

   line_write_buf i_line_write_buf (
      .Clk, .rst_i,
      .evict (evict.slave),
      .mem_aw_o, .mem_awaddr_o, .mem_wvalid_o, .mem_wdata_o, .mem_wready_i
   );

endmodule

`default_nettype wire

// File: line_write_buf.sv
`timescale 1ns/10ps
`default_nettype none

module line_write_buf (
   input  logic                Clk,
   input  logic                rst_i,
   evict_if.slave              evict,
   // Memory write channel
   output logic                mem_aw_o,
   output soc_addr_pkg::addr_t mem_awaddr_o,
   output logic                mem_wvalid_o,
   output soc_addr_pkg::word_t mem_wdata_o,
   input  logic                mem_wready_i
);
   import soc_addr_pkg::*;
   import dcache_pkg::*;

   line_t line_q;
   addr_t addr_q;
   woff_t beat_q;
   logic  busy_q;
   logic  aw_q;
   logic  wvalid_q;

   always_ff @(posedge Clk) begin
      if (rst_i) begin
         busy_q   <= 1'b0;
         aw_q     <= 1'b0;
         wvalid_q <= 1'b0;
         beat_q   <= '0;
      end else begin
         aw_q <= 1'b0;
         if (evict.start && !busy_q) begin
            busy_q <= 1'b1;
            aw_q   <= 1'b1;
            beat_q <= '0;
         end
         // Data phase opens right after the address strobe
         if (aw_q) wvalid_q <= 1'b1;
         if (wvalid_q && mem_wready_i) begin
            if (beat_q == woff_t'(LINE_WORDS - 1)) begin
               wvalid_q <= 1'b0;
               busy_q   <= 1'b0;
            end else begin
               beat_q <= beat_q + 3'd1;
            end
         end
      end
   end

   // Whole victim copied in one cycle
   always_ff @(posedge Clk) begin
      if (evict.start && !busy_q) begin
         line_q <= evict.line;
         addr_q <= evict.addr;
      end
   end

   assign mem_aw_o     = aw_q;
   assign mem_awaddr_o = addr_q;
   assign mem_wvalid_o = wvalid_q;
   assign mem_wdata_o  = line_q[beat_q];
   assign evict.idle   = ~busy_q;

endmodule

`default_nettype wire

// File: linefill_buf.sv
`timescale 1ns/10ps
`default_nettype none

module linefill_buf (
   input  logic                Clk,
   input  logic                rst_i,
   fill_if.slave               fill,
   // Memory read channel
   output logic                mem_ar_o,
   output soc_addr_pkg::addr_t mem_araddr_o,
   input  logic                mem_rvalid_i,
   input  soc_addr_pkg::word_t mem_rdata_i
);
   import soc_addr_pkg::*;
   import dcache_pkg::*;

   addr_view_u addr_q;
   woff_t      crit_woff;
   woff_t      slot_q;
   line_t      line_q;
   logic       active_q;
   logic       ar_q;
   logic       crit_valid_q;
   logic       line_done_q;

   assign crit_woff = addr_q.cache_view.woff;

   always_ff @(posedge Clk) begin
      if (rst_i) begin
         active_q     <= 1'b0;
         ar_q         <= 1'b0;
         crit_valid_q <= 1'b0;
         line_done_q  <= 1'b0;
         slot_q       <= '0;
      end else begin
         ar_q         <= 1'b0;
         crit_valid_q <= 1'b0;
         line_done_q  <= 1'b0;
         if (fill.start) begin
            active_q <= 1'b1;
            ar_q     <= 1'b1;
            slot_q   <= fill.addr[4:2];
         end else if (active_q && mem_rvalid_i) begin
            // Slot counter wraps inside the line
            slot_q <= slot_q + 3'd1;
            if (slot_q == crit_woff) crit_valid_q <= 1'b1;
            // Last beat lands just below the critical slot
            if (slot_q == crit_woff - 3'd1) begin
               line_done_q <= 1'b1;
               active_q    <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge Clk) begin
      if (fill.start) addr_q <= fill.addr;
      if (active_q && mem_rvalid_i) line_q[slot_q] <= mem_rdata_i;
   end

   assign mem_ar_o     = ar_q;
   assign mem_araddr_o = addr_q;

   assign fill.crit_valid = crit_valid_q;
   assign fill.crit_word  = line_q[crit_woff];
   assign fill.line_done  = line_done_q;
   assign fill.line       = line_q;

endmodule

`default_nettype wire

// File: dcache.sv
`timescale 1ns/10ps
`default_nettype none

module dcache (
   input  logic    Clk,
   input  logic    rst_i,
   dreq_if.slave   dreq,
   fill_if.master  fill,
   evict_if.master evict
);
   import soc_addr_pkg::*;
   import dcache_pkg::*;

   localparam logic [1:0] S_IDLE  = 2'd0;
   localparam logic [1:0] S_HIT   = 2'd1;
   localparam logic [1:0] S_MISS  = 2'd2;
   localparam logic [1:0] S_DRAIN = 2'd3;

   // Arrays
   tag_t                 tag_q [NUM_LINES];
   line_t                data_q [NUM_LINES];
   logic [NUM_LINES-1:0] valid_q;
   logic [NUM_LINES-1:0] dirty_q;

   // Incoming request decode
   addr_view_u in_view;
   index_t     in_idx;
   woff_t      in_woff;
   logic       hit;

   // Held request during a miss
   addr_view_u req_q;
   logic       req_we_q;
   word_t      req_wdata_q;
   index_t     req_idx;
   woff_t      req_woff;

   logic [1:0] state_q;
   logic       done_q;
   word_t      rdata_q;
   logic       fill_start_q;
   logic       evict_start_q;
   line_t      fill_line;

   assign in_view = dreq.addr;
   assign in_idx  = in_view.cache_view.index;
   assign in_woff = in_view.cache_view.woff;
   assign hit     = valid_q[in_idx] && (tag_q[in_idx] == in_view.cache_view.tag);

   assign req_idx  = req_q.cache_view.index;
   assign req_woff = req_q.cache_view.woff;

   ////////////////////////////////////////
   // Sequencer and line state
   ////////////////////////////////////////

   always_ff @(posedge Clk) begin
      if (rst_i) begin
         state_q       <= S_IDLE;
         valid_q       <= '0;
         dirty_q       <= '0;
         done_q        <= 1'b0;
         fill_start_q  <= 1'b0;
         evict_start_q <= 1'b0;
      end else begin
         done_q        <= 1'b0;
         fill_start_q  <= 1'b0;
         evict_start_q <= 1'b0;
         case (state_q)
            S_IDLE: begin
               if (dreq.req && hit) begin
                  done_q  <= 1'b1;
                  state_q <= S_HIT;
                  if (dreq.we) dirty_q[in_idx] <= 1'b1;
               end else if (dreq.req) begin
                  // Dirty victim leaves together with the fill request
                  fill_start_q  <= 1'b1;
                  evict_start_q <= valid_q[in_idx] & dirty_q[in_idx];
                  state_q       <= S_MISS;
               end
            end
            S_HIT: state_q <= S_IDLE;
            S_MISS: begin
               // Early restart on reads
               if (fill.crit_valid && !req_we_q) done_q <= 1'b1;
               if (fill.line_done) begin
                  valid_q[req_idx] <= 1'b1;
                  dirty_q[req_idx] <= req_we_q;
                  if (req_we_q) done_q <= 1'b1;
                  state_q <= S_DRAIN;
               end
            end
            default: if (evict.idle) state_q <= S_IDLE;
         endcase
      end
   end

   ////////////////////////////////////////
   // Data path
   ////////////////////////////////////////

   // Write word merged over the fetched line
   always_comb begin
      fill_line = fill.line;
      if (req_we_q) fill_line[req_woff] = req_wdata_q;
   end

   always_ff @(posedge Clk) begin
      if (state_q == S_IDLE && dreq.req) begin
         req_q       <= dreq.addr;
         req_we_q    <= dreq.we;
         req_wdata_q <= dreq.wdata;
         rdata_q     <= data_q[in_idx][in_woff];
         if (hit && dreq.we) data_q[in_idx][in_woff] <= dreq.wdata;
      end
      if (state_q == S_MISS && fill.crit_valid) rdata_q <= fill.crit_word;
      if (state_q == S_MISS && fill.line_done) begin
         data_q[req_idx] <= fill_line;
         tag_q[req_idx]  <= req_q.cache_view.tag;
      end
   end

   assign dreq.done  = done_q;
   assign dreq.rdata = rdata_q;
   assign dreq.busy  = (state_q != S_IDLE);

   // Victim still sits in the store until line_done
   assign fill.start  = fill_start_q;
   assign fill.addr   = {req_q[31:2], 2'b00};
   assign evict.start = evict_start_q;
   assign evict.addr  = {tag_q[req_idx], req_idx, 5'b00000};
   assign evict.line  = data_q[req_idx];

endmodule

`default_nettype wire

// File: mem_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module mem_ctrl #(
   parameter soc_addr_pkg::region_t PERIPH_REGION = 4'h4
) (
   input  logic                Clk,
   input  logic                rst_i,
   // Core side
   input  logic                req_i,
   input  logic                req_we_i,
   input  soc_addr_pkg::addr_t req_addr_i,
   input  soc_addr_pkg::word_t req_wdata_i,
   output logic                done_o,
   output logic                busy_o,
   output soc_addr_pkg::word_t rdata_o,
   // Peripheral word port
   output logic                per_rd_o,
   output logic                per_wr_o,
   output soc_addr_pkg::addr_t per_addr_o,
   output soc_addr_pkg::word_t per_wdata_o,
   input  logic                per_done_i,
   input  soc_addr_pkg::word_t per_rdata_i,
   // Cached path
   dreq_if.master              dreq
);
   import soc_addr_pkg::*;

   localparam logic [1:0] P_IDLE  = 2'd0;
   localparam logic [1:0] P_ISSUE = 2'd1;
   localparam logic [1:0] P_WAIT  = 2'd2;
   localparam logic [1:0] P_DONE  = 2'd3;

   addr_view_u req_view;
   logic       is_periph;
   logic [1:0] pstate_q;
   logic       pwe_q;
   addr_t      paddr_q;
   word_t      pwdata_q;
   word_t      prdata_q;

   ////////////////////////////////////////
   // Region decode
   ////////////////////////////////////////

   assign req_view  = req_addr_i;
   assign is_periph = (req_view.region_view.region == PERIPH_REGION);

   // Cached accesses pass straight through
   assign dreq.req   = req_i & ~is_periph;
   assign dreq.we    = req_we_i;
   assign dreq.addr  = req_addr_i;
   assign dreq.wdata = req_wdata_i;

   ////////////////////////////////////////
   // Peripheral access FSM
   ////////////////////////////////////////

   always_ff @(posedge Clk) begin
      if (rst_i) begin
         pstate_q <= P_IDLE;
      end else begin
         case (pstate_q)
            P_IDLE:  if (req_i && is_periph) pstate_q <= P_ISSUE;
            P_ISSUE: pstate_q <= P_WAIT;
            P_WAIT:  if (per_done_i) pstate_q <= P_DONE;
            default: pstate_q <= P_IDLE;
         endcase
      end
   end

   always_ff @(posedge Clk) begin
      if (pstate_q == P_IDLE && req_i && is_periph) begin
         paddr_q  <= req_addr_i;
         pwdata_q <= req_wdata_i;
         pwe_q    <= req_we_i;
      end
      if (pstate_q == P_WAIT && per_done_i) begin
         prdata_q <= per_rdata_i;
      end
   end

   assign per_rd_o    = (pstate_q == P_ISSUE) & ~pwe_q;
   assign per_wr_o    = (pstate_q == P_ISSUE) & pwe_q;
   assign per_addr_o  = paddr_q;
   assign per_wdata_o = pwdata_q;

   // Response merge
   assign done_o  = dreq.done | (pstate_q == P_DONE);
   assign rdata_o = (pstate_q == P_DONE) ? prdata_q : dreq.rdata;
   assign busy_o  = (pstate_q != P_IDLE) | dreq.busy;

endmodule

`default_nettype wire

// File: dcache_ifs.sv
`timescale 1ns/10ps
`default_nettype none

// Word request from the memory controller into the cache
interface dreq_if;
   import soc_addr_pkg::*;

   logic  req;
   logic  we;
   addr_t addr;
   word_t wdata;
   logic  done;
   word_t rdata;
   logic  busy;

   modport master (output req, we, addr, wdata, input done, rdata, busy);
   modport slave  (input req, we, addr, wdata, output done, rdata, busy);
endinterface

// Line fetch request to the linefill buffer
interface fill_if;
   import soc_addr_pkg::*;
   import dcache_pkg::*;

   logic  start;
   addr_t addr;
   logic  crit_valid;
   word_t crit_word;
   logic  line_done;
   line_t line;

   modport master (output start, addr, input crit_valid, crit_word, line_done, line);
   modport slave  (input start, addr, output crit_valid, crit_word, line_done, line);
endinterface

// Victim line handoff to the line write buffer
interface evict_if;
   import soc_addr_pkg::*;
   import dcache_pkg::*;

   logic  start;
   addr_t addr;
   line_t line;
   logic  idle;

   modport master (output start, addr, line, input idle);
   modport slave  (input start, addr, line, output idle);
endinterface

`default_nettype wire

// File: dcache_pkg.sv
`default_nettype none

package dcache_pkg;

   ////////////////////////////////////////
   // Cache geometry
   ////////////////////////////////////////

   localparam int unsigned LINE_WORDS = 8;
   localparam int unsigned NUM_LINES  = 8;

   ////////////////////////////////////////
   // Line and address field types
   ////////////////////////////////////////

   // 256-bit line, word 0 in the low bits
   typedef soc_addr_pkg::word_t [LINE_WORDS-1:0] line_t;

   typedef logic [23:0] tag_t;
   typedef logic [2:0]  index_t;

   // Word slot within a line
   typedef logic [2:0]  woff_t;

endpackage

`default_nettype wire

// File: soc_addr_pkg.sv
`default_nettype none

package soc_addr_pkg;

   ////////////////////////////////////////
   // Basic word types
   ////////////////////////////////////////

   // Byte address, always word aligned on this bus
   typedef logic [31:0] addr_t;
   typedef logic [31:0] word_t;

   // Top nibble selects the address region
   typedef logic [3:0] region_t;

   ////////////////////////////////////////
   // One address, two decodings
   ////////////////////////////////////////

   typedef union packed {
      // Region decode for the memory controller
      struct packed {
         region_t     region;
         logic [27:0] offset;
      } region_view;
      // Cache decode, 8 lines of 8 words
      struct packed {
         logic [23:0] tag;
         logic [2:0]  index;
         logic [2:0]  woff;
         logic [1:0]  boff;
      } cache_view;
   } addr_view_u;

endpackage

`default_nettype wire
